// File: rm_pkg.sv
package rm_pkg;

  // Active picture, reduced for simulation.
  localparam int DISPLAY_WIDTH  = 32;
  localparam int DISPLAY_HEIGHT = 24;

  // Full raster including blanking.
  localparam int H_TOTAL = 40;
  localparam int V_TOTAL = 28;

  // Sync pulses are low from START up to but not including END.
  localparam int H_SYNC_START = 34;
  localparam int H_SYNC_END   = 36;
  localparam int V_SYNC_START = 25;
  localparam int V_SYNC_END   = 27;

  localparam int H_BITS     = 5;
  localparam int V_BITS     = 5;
  localparam int ADDR_BITS  = H_BITS + V_BITS;
  // The horizontal counter runs past 31 into blanking.
  localparam int H_CNT_BITS = 6;

  localparam int FB_DEPTH = DISPLAY_WIDTH * DISPLAY_HEIGHT;

  // Q8.8 signed fixed point.
  typedef logic signed [15:0] fp_t;

  localparam fp_t FP_ONE = 16'sd256;

  typedef struct packed {
    fp_t x;
    fp_t y;
    fp_t z;
  } vec3;

  // Camera sits three units behind the origin, looking along +z.
  localparam vec3 CAM_POS = '{x: 16'sd0, y: 16'sd0, z: -16'sd768};

  // 1/16 per pixel of screen offset.
  localparam fp_t DIR_STEP = 16'sd16;

  localparam int  MAX_STEPS = 15;
  localparam fp_t HIT_EPS   = 16'sd16;
  localparam fp_t FAR_Z     = 16'sd768;

  typedef logic [3:0] color_t;

  typedef enum logic {
    SHAPE_CUBE = 1'b0,
    SHAPE_OCTA = 1'b1
  } shape_e;

  // One pixel write from the marcher.
  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    color_t               color;
  } pix_wr_t;

endpackage

// File: ray_marcher.sv
`timescale 1ns/1ps
`default_nettype none

module ray_marcher (
  input  logic            clk_in,
  input  logic            rst_n,
  input  rm_pkg::shape_e  shape_sel,
  input  logic            swap_pending,
  output rm_pkg::pix_wr_t wr,
  output logic            wr_valid,
  output logic            frame_done
);
  import rm_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SETUP,
    S_DIST,
    S_DECIDE,
    S_DONE
  } state_e;

  state_e            state;
  logic [H_BITS-1:0] h;
  logic [V_BITS-1:0] v;
  logic [3:0]        n;
  shape_e            shape_q;
  vec3               pos;
  vec3               dir;
  fp_t               d;
  logic              hit;
  logic              miss;
  logic              last_pix;

  function automatic fp_t abs_fp(fp_t a);
    return (a < 0) ? -a : a;
  endfunction

  // Product of two Q8.8 values, back in Q8.8.
  function automatic fp_t scale(fp_t a, fp_t b);
    logic signed [31:0] prod;
    prod = a * b;
    return prod[23:8];
  endfunction

  // Distance to the selected shape. Both use norms that need no square root.
  function automatic fp_t field(vec3 p, shape_e s);
    fp_t ax;
    fp_t ay;
    fp_t az;
    fp_t m;
    fp_t sum;
    ax = abs_fp(p.x);
    ay = abs_fp(p.y);
    az = abs_fp(p.z);
    m = (ax > ay) ? ax : ay;
    m = (m > az) ? m : az;
    sum = ax + ay + az - FP_ONE;
    if (s == SHAPE_CUBE) begin
      return m - FP_ONE;
    end
    return sum >>> 1;
  endfunction

  assign hit      = d < HIT_EPS;
  assign miss     = (n == 4'(MAX_STEPS)) || (pos.z > FAR_Z);
  assign last_pix = (h == H_BITS'(DISPLAY_WIDTH - 1)) && (v == V_BITS'(DISPLAY_HEIGHT - 1));

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      h          <= '0;
      v          <= '0;
      shape_q    <= SHAPE_CUBE;
      wr_valid   <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      wr_valid   <= 1'b0;
      frame_done <= 1'b0;
      case (state)
        // Hold off until the buffer manager has taken the last frame.
        S_IDLE: begin
          if (!swap_pending && !frame_done) begin
            h       <= '0;
            v       <= '0;
            shape_q <= shape_sel;
            state   <= S_SETUP;
          end
        end
        S_SETUP: state <= S_DIST;
        S_DIST:  state <= S_DECIDE;
        S_DECIDE: begin
          if (hit || miss) begin
            wr_valid <= 1'b1;
            if (last_pix) begin
              state <= S_DONE;
            end else begin
              state <= S_SETUP;
              if (h == H_BITS'(DISPLAY_WIDTH - 1)) begin
                h <= '0;
                v <= v + 1'b1;
              end else begin
                h <= h + 1'b1;
              end
            end
          end else begin
            state <= S_DIST;
          end
        end
        S_DONE: begin
          frame_done <= 1'b1;
          state      <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    case (state)
      S_SETUP: begin
        pos   <= CAM_POS;
        n     <= '0;
        dir.x <= (fp_t'(h) - fp_t'(DISPLAY_WIDTH / 2)) * DIR_STEP;
        dir.y <= (fp_t'(v) - fp_t'(DISPLAY_HEIGHT / 2)) * DIR_STEP;
        dir.z <= FP_ONE;
      end
      S_DIST: d <= field(pos, shape_q);
      S_DECIDE: begin
        if (hit || miss) begin
          wr.addr  <= {v, h};
          // Fewer steps to the surface gives a brighter pixel.
          wr.color <= hit ? color_t'(4'd15 - n) : '0;
        end else begin
          pos.x <= pos.x + scale(dir.x, d);
          pos.y <= pos.y + scale(dir.y, d);
          pos.z <= pos.z + scale(dir.z, d);
          n     <= n + 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: bram_manager.sv
`timescale 1ns/1ps
`default_nettype none

module bram_manager (
  input  logic                         clk_in,
  input  logic                         rst_n,
  input  logic                         frame_done,
  input  logic                         frame_start,
  input  rm_pkg::pix_wr_t              wr,
  input  logic                         wr_valid,
  input  logic [rm_pkg::ADDR_BITS-1:0] rd_addr,
  output rm_pkg::color_t               rd_data,
  output logic                         swap_pending
);
  import rm_pkg::*;

  color_t mem [2][FB_DEPTH];
  // Buffer currently shown. The marcher fills the other one.
  logic   which_buf;

  // Both buffers power up black.
  initial begin
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < FB_DEPTH; i++) begin
        mem[b][i] = '0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_valid) begin
      mem[!which_buf][wr.addr] <= wr.color;
    end
    rd_data <= mem[which_buf][rd_addr];
  end

  // A finished frame is only handed over at the top of the display raster.
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      which_buf    <= 1'b0;
      swap_pending <= 1'b0;
    end else begin
      if (frame_start && swap_pending) begin
        which_buf    <= !which_buf;
        swap_pending <= 1'b0;
      end
      if (frame_done) begin
        swap_pending <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: vga_display.sv
`timescale 1ns/1ps
`default_nettype none

module vga_display (
  input  logic                         clk_in,
  input  logic                         rst_n,
  input  rm_pkg::color_t               rd_data,
  output logic [rm_pkg::ADDR_BITS-1:0] rd_addr,
  output logic                         frame_start,
  output logic [3:0]                   vga_r,
  output logic [3:0]                   vga_g,
  output logic [3:0]                   vga_b,
  output logic                         vga_hs,
  output logic                         vga_vs
);
  import rm_pkg::*;

  logic [H_CNT_BITS-1:0] hcount;
  logic [V_BITS-1:0]     vcount;
  logic                  active0;
  logic                  hs0;
  logic                  vs0;
  logic                  active1;
  logic                  hs1;
  logic                  vs1;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      hcount <= '0;
      vcount <= '0;
    end else if (hcount == H_CNT_BITS'(H_TOTAL - 1)) begin
      hcount <= '0;
      vcount <= (vcount == V_BITS'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  assign active0 = (hcount < H_CNT_BITS'(DISPLAY_WIDTH)) && (vcount < V_BITS'(DISPLAY_HEIGHT));
  assign hs0     = !((hcount >= H_CNT_BITS'(H_SYNC_START)) && (hcount < H_CNT_BITS'(H_SYNC_END)));
  assign vs0     = !((vcount >= V_BITS'(V_SYNC_START)) && (vcount < V_BITS'(V_SYNC_END)));

  // Width is a power of two, so the address is just the two counters side by side.
  assign rd_addr     = active0 ? {vcount, hcount[H_BITS-1:0]} : '0;
  assign frame_start = (hcount == '0) && (vcount == '0);

  // Stage one waits out the buffer read, stage two registers the pins.
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      active1 <= 1'b0;
      hs1     <= 1'b1;
      vs1     <= 1'b1;
      vga_hs  <= 1'b1;
      vga_vs  <= 1'b1;
      vga_r   <= '0;
      vga_g   <= '0;
      vga_b   <= '0;
    end else begin
      active1 <= active0;
      hs1     <= hs0;
      vs1     <= vs0;
      vga_hs  <= hs1;
      vga_vs  <= vs1;
      vga_r   <= active1 ? rd_data : '0;
      vga_g   <= active1 ? rd_data : '0;
      vga_b   <= active1 ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

// File: top_level_main.sv
`timescale 1ns/1ps
`default_nettype none

module top_level_main (
  input  logic           clk_in,
  input  logic           rst_n,
  input  rm_pkg::shape_e sw,
  output logic [3:0]     vga_r,
  output logic [3:0]     vga_g,
  output logic [3:0]     vga_b,
  output logic           vga_hs,
  output logic           vga_vs
);
  import rm_pkg::*;

  pix_wr_t              wr;
  logic                 wr_valid;
  logic                 frame_done;
  logic                 swap_pending;
  logic                 frame_start;
  logic [ADDR_BITS-1:0] rd_addr;
  color_t               rd_data;

  ray_marcher ray_marcher_inst (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .shape_sel    (sw),
    .swap_pending (swap_pending),
    .wr           (wr),
    .wr_valid     (wr_valid),
    .frame_done   (frame_done)
  );

  bram_manager bram_manager_inst (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .frame_done   (frame_done),
    .frame_start  (frame_start),
    .wr           (wr),
    .wr_valid     (wr_valid),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .swap_pending (swap_pending)
  );

  vga_display vga_display_inst (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .frame_start (frame_start),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs)
  );

endmodule

`default_nettype wire

// File: tb_top_level_main.sv
`timescale 1ns/1ps

module tb_top_level_main;
  import rm_pkg::*;

  logic        clk_in;
  logic        rst_n;
  shape_e      sw;
  logic [3:0]  vga_r;
  logic [3:0]  vga_g;
  logic [3:0]  vga_b;
  logic        vga_hs;
  logic        vga_vs;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          swaps = 0;
  logic        sp_q;
  logic [31:0] lfsr;
  color_t      ref_img [2][FB_DEPTH];
  color_t      frame_img [FB_DEPTH];

  top_level_main uut (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .sw     (sw),
    .vga_r  (vga_r),
    .vga_g  (vga_g),
    .vga_b  (vga_b),
    .vga_hs (vga_hs),
    .vga_vs (vga_vs)
  );

  initial begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  // Four worst-case marcher frames plus ten display frames.
  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= 4 * FB_DEPTH * 33 + 10 * H_TOTAL * V_TOTAL) begin
      $display("Timeout: the DUT did not finish the tests within %0d cycles", cycles);
      $display("Errors: %0d of %0d checks", errors, checks);
      $display("Some tests failed");
      $finish;
    end
  end

  // A completed swap shows up as swap_pending falling.
  always @(negedge clk_in) begin
    if (sp_q && !uut.bram_manager_inst.swap_pending) begin
      swaps++;
    end
    sp_q = uut.bram_manager_inst.swap_pending;
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int width, output int value);
    value = 0;
    for (int i = 0; i < width; i++) begin
      lfsr = lfsr_step(lfsr);
      value = value * 2 + int'(lfsr[0]);
    end
  endtask

  // Expected gray level of one pixel, straight from the marching rule.
  function automatic color_t render_pixel(int h, int v, shape_e s);
    fp_t px;
    fp_t py;
    fp_t pz;
    fp_t dx;
    fp_t dy;
    fp_t dz;
    fp_t d;
    int  ax;
    int  ay;
    int  az;
    int  m;
    dx = fp_t'((h - DISPLAY_WIDTH / 2) * int'(DIR_STEP));
    dy = fp_t'((v - DISPLAY_HEIGHT / 2) * int'(DIR_STEP));
    dz = FP_ONE;
    px = CAM_POS.x;
    py = CAM_POS.y;
    pz = CAM_POS.z;
    for (int n = 0; n <= MAX_STEPS; n++) begin
      ax = px[15] ? -int'(px) : int'(px);
      ay = py[15] ? -int'(py) : int'(py);
      az = pz[15] ? -int'(pz) : int'(pz);
      m = ax;
      if (ay > m) m = ay;
      if (az > m) m = az;
      if (s == SHAPE_CUBE) begin
        d = fp_t'(m - int'(FP_ONE));
      end else begin
        d = fp_t'((ax + ay + az - int'(FP_ONE)) >>> 1);
      end
      if (d < HIT_EPS) return color_t'(15 - n);
      if (n == MAX_STEPS || pz > FAR_Z) return '0;
      px = px + fp_t'((int'(dx) * int'(d)) >>> 8);
      py = py + fp_t'((int'(dy) * int'(d)) >>> 8);
      pz = pz + fp_t'((int'(dz) * int'(d)) >>> 8);
    end
    return '0;
  endfunction

  task automatic compare_color(input color_t got, input color_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_idle_outputs();
    compare_bit(vga_hs, 1'b1, "vga_hs around reset");
    compare_bit(vga_vs, 1'b1, "vga_vs around reset");
    compare_color(vga_r, '0, "vga_r around reset");
    compare_color(vga_g, '0, "vga_g around reset");
    compare_color(vga_b, '0, "vga_b around reset");
  endtask

  task automatic wait_vs_fall();
    while (!vga_vs) @(negedge clk_in);
    do @(negedge clk_in); while (vga_vs);
  endtask

  // Samples one full raster from the vsync fall, checking syncs and blanking on the way.
  task automatic capture_frame();
    int pos;
    int h;
    int v;
    wait_vs_fall();
    for (int k = 0; k < H_TOTAL * V_TOTAL; k++) begin
      if (k > 0) @(negedge clk_in);
      pos = (V_SYNC_START * H_TOTAL + k) % (H_TOTAL * V_TOTAL);
      h = pos % H_TOTAL;
      v = pos / H_TOTAL;
      compare_bit(vga_hs, !(h >= H_SYNC_START && h < H_SYNC_END),
                  $sformatf("vga_hs at (%0d,%0d)", h, v));
      compare_bit(vga_vs, !(v >= V_SYNC_START && v < V_SYNC_END),
                  $sformatf("vga_vs at (%0d,%0d)", h, v));
      if (h < DISPLAY_WIDTH && v < DISPLAY_HEIGHT) begin
        frame_img[v * DISPLAY_WIDTH + h] = vga_r;
        compare_color(vga_g, vga_r, $sformatf("vga_g against vga_r at (%0d,%0d)", h, v));
        compare_color(vga_b, vga_r, $sformatf("vga_b against vga_r at (%0d,%0d)", h, v));
      end else begin
        compare_color(vga_r, '0, $sformatf("vga_r in blanking at (%0d,%0d)", h, v));
        compare_color(vga_g, '0, $sformatf("vga_g in blanking at (%0d,%0d)", h, v));
        compare_color(vga_b, '0, $sformatf("vga_b in blanking at (%0d,%0d)", h, v));
      end
    end
  endtask

  function automatic int frame_error_count(shape_e s);
    int bad;
    bad = 0;
    for (int i = 0; i < FB_DEPTH; i++) begin
      if (frame_img[i] !== ref_img[s][i]) bad++;
    end
    return bad;
  endfunction

  function automatic bit frame_is_blank();
    for (int i = 0; i < FB_DEPTH; i++) begin
      if (frame_img[i] !== '0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_frame(input shape_e s, input string name);
    for (int i = 0; i < FB_DEPTH; i++) begin
      compare_color(frame_img[i], ref_img[s][i], $sformatf("%s pixel %0d", name, i));
    end
  endtask

  // A shown frame is one whole shape image, or black before anything was swapped in.
  task automatic check_no_tearing(input bit blank_ok);
    checks++;
    if (frame_error_count(SHAPE_CUBE) == 0 || frame_error_count(SHAPE_OCTA) == 0) return;
    if (blank_ok && frame_is_blank()) return;
    errors++;
    $display("FAIL %0t: captured frame is not a single complete shape image", $time);
  endtask

  task automatic test_reset();
    repeat (2) begin
      @(negedge clk_in);
      check_idle_outputs();
    end
    @(posedge clk_in);
    rst_n <= 1'b1;
    repeat (2) begin
      @(negedge clk_in);
      check_idle_outputs();
    end
  endtask

  task automatic test_cube_frame();
    while (swaps == 0) begin
      capture_frame();
      check_no_tearing(1'b1);
    end
    capture_frame();
    check_frame(SHAPE_CUBE, "cube");
  endtask

  task automatic test_octa_switch();
    int target;
    @(posedge clk_in);
    sw <= SHAPE_OCTA;
    target = swaps + 2;
    while (swaps < target) begin
      capture_frame();
      check_no_tearing(1'b0);
    end
    capture_frame();
    check_frame(SHAPE_OCTA, "octahedron");
  endtask

  task automatic report_samples();
    int r;
    int idx;
    for (int i = 0; i < 4; i++) begin
      random_bits(10, r);
      idx = r % FB_DEPTH;
      $display("Sample pixel (%0d,%0d): cube %0d, octahedron %0d, shown %0d",
               idx % DISPLAY_WIDTH, idx / DISPLAY_WIDTH,
               ref_img[0][idx], ref_img[1][idx], frame_img[idx]);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    sw    = SHAPE_CUBE;
    sp_q  = 1'b0;
    lfsr  = 32'hf93d7a85;
    for (int s = 0; s < 2; s++) begin
      for (int v = 0; v < DISPLAY_HEIGHT; v++) begin
        for (int h = 0; h < DISPLAY_WIDTH; h++) begin
          ref_img[s][v * DISPLAY_WIDTH + h] = render_pixel(h, v, shape_e'(s));
        end
      end
    end
    test_reset();
    test_cube_frame();
    report_samples();
    test_octa_switch();
    report_samples();
    $display("Errors: %0d of %0d checks, %0d swaps seen", errors, checks, swaps);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
rm_pkg.sv
ray_marcher.sv
bram_manager.sv
vga_display.sv
top_level_main.sv
tb_top_level_main.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top_level_main
FLAGS     ?= --timing
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
PASS_MSG  := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
